/* files.f */
verilog/llc_pkg.sv
verilog/llc_updown_counter.sv
verilog/llc_miss_counters.sv
verilog/llc_miss_fifo.sv
verilog/llc_desc_router.sv
verilog/llc_miss_guard_top.sv
dv/tb_clk_gen.sv
dv/tb_llc_miss_guard.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the miss guard testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing \
  -f files.f \
  --top-module tb_llc_miss_guard \
  -o tb_sim
if [ $? -ne 0 ]; then
  echo "compile step failed"
  exit 1
fi

./obj_dir/tb_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

grep -q "SIMULATION PASSED" "$log"
if [ $? -ne 0 ]; then
  echo "pass message not found in $log"
  exit 1
fi

echo "run passed"
exit 0

/* dv/tb_llc_miss_guard.sv */
`timescale 1ns/10ps

module tb_llc_miss_guard;

  import llc_pkg::*;

  localparam int unsigned NumDesc = 600;
  localparam int unsigned WatchdogNs = NumDesc * 40 * 20;

  logic        clk;
  logic        reset;
  logic        desc_valid;
  llc_desc_t   desc;
  logic        desc_ready;
  logic        hit_valid;
  llc_desc_t   hit_desc;
  logic        hit_ready;
  logic        miss_valid;
  llc_desc_t   miss_desc;
  logic        miss_ready;

  integer      seed;
  // the reference counts as they stand after the last edge
  int unsigned id_cnt [NoCounters];
  int unsigned wcnt;
  llc_desc_t   miss_q [$];
  // handshakes are predicted before the edge and applied on it
  logic        accept;
  logic        pop;
  logic        route_miss;
  int unsigned issued;
  // transfers as the DUT shows them on its ports
  int unsigned accepted;
  int unsigned hit_cnt;
  int unsigned pop_cnt;
  int unsigned stall_cycles;
  int unsigned full_cycles;
  logic        miss_low;
  int unsigned stretch_left;
  logic        done;

  tb_clk_gen #(
    .PeriodNs ( 40 )
  ) u_clk_gen (
    .clk_o ( clk )
  );

  llc_miss_guard_top u_dut (
    .clk_i        ( clk        ),
    .reset_i      ( reset      ),
    .desc_valid_i ( desc_valid ),
    .desc_i       ( desc       ),
    .desc_ready_o ( desc_ready ),
    .hit_valid_o  ( hit_valid  ),
    .hit_o        ( hit_desc   ),
    .hit_ready_i  ( hit_ready  ),
    .miss_valid_o ( miss_valid ),
    .miss_o       ( miss_desc  ),
    .miss_ready_i ( miss_ready )
  );

  function automatic int unsigned rand_below(input int unsigned n);
    int unsigned r;
    r = $unsigned($random(seed));
    return r % n;
  endfunction

  task automatic report_fail();
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at the first mismatch");
  endtask

  task automatic check_ready(input logic exp);
    if (desc_ready !== exp) begin
      $display("error at %0d ns: desc_ready_o is %b, expected %b", $time, desc_ready, exp);
      report_fail();
    end
  endtask

  task automatic check_valid(input logic exp, input logic act, input string what);
    if (act !== exp) begin
      $display("error at %0d ns: %s is %b, expected %b", $time, what, act, exp);
      report_fail();
    end
  endtask

  task automatic check_hit(input llc_desc_t exp);
    if (hit_desc !== exp) begin
      $display("error at %0d ns: hit_o is %h, expected %h", $time, hit_desc, exp);
      report_fail();
    end
  endtask

  task automatic check_miss(input llc_desc_t exp);
    if (miss_desc !== exp) begin
      $display("error at %0d ns: miss_o is %h, expected %h", $time, miss_desc, exp);
      report_fail();
    end
  endtask

  // apply the transfers that were predicted for the edge just passed
  task automatic update_model();
    llc_desc_t d;
    if (pop) begin
      d = miss_q.pop_front();
      id_cnt[d.id[UseIdBits-1:0]]--;
      if (d.rw) begin
        wcnt--;
      end
    end
    // a pop is applied first so a push on the same edge nets out
    if (accept && route_miss) begin
      miss_q.push_back(desc);
      id_cnt[desc.id[UseIdBits-1:0]]++;
      if (desc.rw) begin
        wcnt++;
      end
    end
  endtask

  task automatic drive_inputs();
    // a waiting descriptor keeps its data until it is taken
    if (!(desc_valid && !accept)) begin
      desc_valid = (issued < NumDesc) && (rand_below(100) < 80);
      desc.id    = llc_id_t'(rand_below(6));
      desc.rw    = (rand_below(100) < 40);
      // the first descriptors are all hits so the bypass is seen on its own
      desc.miss  = (issued >= 32) && (rand_below(100) < 30);
      desc.tag   = 8'(issued);
      if (desc_valid) begin
        issued++;
      end
    end
    hit_ready = (rand_below(100) < 75);
    // miss_ready alternates long low stretches with random toggling
    if (stretch_left == 0) begin
      miss_low     = !miss_low;
      stretch_left = miss_low ? 8 + rand_below(33) : 4 + rand_below(17);
    end
    stretch_left--;
    miss_ready = miss_low ? 1'b0 : (rand_below(100) < 70);
  endtask

  task automatic predict_and_check();
    logic stall;
    logic exp_ready;
    stall = (wcnt == (2 ** MissCntWWidth) - 1);
    for (int unsigned i = 0; i < NoCounters; i++) begin
      if (id_cnt[i] == (2 ** MissCntWidth) - 1) begin
        stall = 1'b1;
      end
    end
    // a miss, an older miss of the same low ID, or a write behind a write
    route_miss = desc.miss || (id_cnt[desc.id[UseIdBits-1:0]] != 0) ||
                 (desc.rw && (wcnt != 0));
    exp_ready = !stall && (route_miss ? (miss_q.size() < MissFifoDepth) : hit_ready);
    if (desc_valid) begin
      check_ready(exp_ready);
    end
    check_valid(desc_valid && !route_miss && !stall, hit_valid, "hit_valid_o");
    if (hit_valid) begin
      check_hit(desc);
    end
    check_valid(miss_q.size() != 0, miss_valid, "miss_valid_o");
    if (miss_valid) begin
      check_miss(miss_q[0]);
    end
    // count what the DUT hands over on the coming edge
    if (desc_valid && desc_ready) begin
      accepted++;
    end
    if (hit_valid && hit_ready) begin
      hit_cnt++;
    end
    if (miss_valid && miss_ready) begin
      pop_cnt++;
    end
    if (desc_valid && stall) begin
      stall_cycles++;
    end
    if (desc_valid && !stall && route_miss && (miss_q.size() == MissFifoDepth)) begin
      full_cycles++;
    end
    accept = desc_valid && exp_ready;
    pop    = (miss_q.size() != 0) && miss_ready;
  endtask

  initial begin
    #(WatchdogNs);
    $display("timeout: the run did not finish within %0d ns", WatchdogNs);
    $display("SIMULATION FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    seed         = 32'h98c7_d9fe;
    reset        = 1'b1;
    desc_valid   = 1'b0;
    desc         = '0;
    hit_ready    = 1'b0;
    miss_ready   = 1'b0;
    wcnt         = 0;
    accept       = 1'b0;
    pop          = 1'b0;
    route_miss   = 1'b0;
    issued       = 0;
    accepted     = 0;
    hit_cnt      = 0;
    pop_cnt      = 0;
    stall_cycles = 0;
    full_cycles  = 0;
    miss_low     = 1'b1;
    stretch_left = 0;
    done         = 1'b0;
    for (int unsigned i = 0; i < NoCounters; i++) begin
      id_cnt[i] = 0;
    end
    repeat (4) @(posedge clk);
    #2;
    reset = 1'b0;
    @(negedge clk);
    check_valid(1'b0, hit_valid, "hit_valid_o after reset");
    check_valid(1'b0, miss_valid, "miss_valid_o after reset");
    while (!done) begin
      @(posedge clk);
      update_model();
      #2;
      drive_inputs();
      // outputs are combinational and settled by the falling edge
      @(negedge clk);
      predict_and_check();
      done = (issued == NumDesc) && !desc_valid && (miss_q.size() == 0);
    end
    $display("%0d hits, %0d misses, %0d stall cycles, %0d full cycles",
             hit_cnt, pop_cnt, stall_cycles, full_cycles);
    // every descriptor enters once and leaves once on exactly one output
    if ((accepted != NumDesc) || (hit_cnt + pop_cnt != NumDesc)) begin
      $display("error at %0d ns: %0d accepted, %0d hits and %0d misses for %0d descriptors",
               $time, accepted, hit_cnt, pop_cnt, NumDesc);
      report_fail();
    end else begin
      $display("SIMULATION PASSED");
      $finish;
    end
  end

endmodule

/* dv/tb_clk_gen.sv */
`timescale 1ns/10ps

module tb_clk_gen #(
  parameter int unsigned PeriodNs = 40
) (
  output logic clk_o
);

  // free running clock, low for the first half period
  initial begin
    clk_o = 1'b0;
    forever begin
      #(PeriodNs / 2) clk_o = ~clk_o;
    end
  end

endmodule

/* verilog/llc_miss_guard_top.sv */
`timescale 1ns/10ps

module llc_miss_guard_top (
  input  logic               clk_i,
  input  logic               reset_i,
  // descriptors after tag lookup
  input  logic               desc_valid_i,
  input  llc_pkg::llc_desc_t desc_i,
  output logic               desc_ready_o,
  // descriptors that may bypass the miss pipeline
  output logic               hit_valid_o,
  output llc_pkg::llc_desc_t hit_o,
  input  logic               hit_ready_i,
  // descriptors draining out of the miss pipeline
  output logic               miss_valid_o,
  output llc_pkg::llc_desc_t miss_o,
  input  logic               miss_ready_i
);

  import llc_pkg::*;

  cnt_evt_t cnt_up;
  cnt_evt_t cnt_down;
  logic     to_miss;
  logic     stall;
  logic     fifo_full;
  logic     push;

  llc_desc_router u_router (
    .desc_valid_i ( desc_valid_i ),
    .desc_i       ( desc_i       ),
    .desc_ready_o ( desc_ready_o ),
    .hit_valid_o  ( hit_valid_o  ),
    .hit_o        ( hit_o        ),
    .hit_ready_i  ( hit_ready_i  ),
    .to_miss_i    ( to_miss      ),
    .stall_i      ( stall        ),
    .fifo_full_i  ( fifo_full    ),
    .push_o       ( push         ),
    .cnt_up_o     ( cnt_up       )
  );

  llc_miss_counters u_counters (
    .clk_i      ( clk_i    ),
    .reset_i    ( reset_i  ),
    .cnt_up_i   ( cnt_up   ),
    .cnt_down_i ( cnt_down ),
    .to_miss_o  ( to_miss  ),
    .stall_o    ( stall    )
  );

  // the FIFO stores the input descriptor unchanged
  llc_miss_fifo u_miss_fifo (
    .clk_i        ( clk_i        ),
    .reset_i      ( reset_i      ),
    .push_i       ( push         ),
    .push_desc_i  ( desc_i       ),
    .full_o       ( fifo_full    ),
    .miss_valid_o ( miss_valid_o ),
    .miss_o       ( miss_o       ),
    .miss_ready_i ( miss_ready_i ),
    .cnt_down_o   ( cnt_down     )
  );

endmodule

/* verilog/llc_desc_router.sv */
`timescale 1ns/10ps

module llc_desc_router (
  input  logic               desc_valid_i,
  input  llc_pkg::llc_desc_t desc_i,
  output logic               desc_ready_o,
  output logic               hit_valid_o,
  output llc_pkg::llc_desc_t hit_o,
  input  logic               hit_ready_i,
  // routing hint and back-pressure from the miss counters
  input  logic               to_miss_i,
  input  logic               stall_i,
  input  logic               fifo_full_i,
  output logic               push_o,
  output llc_pkg::cnt_evt_t  cnt_up_o
);

  logic miss_bound;
  logic path_ready;

  // a real miss or an older miss of the same ID or write keeps the order
  assign miss_bound = desc_i.miss | to_miss_i;

  // the chosen path decides whether the descriptor can move this cycle
  assign path_ready = miss_bound ? ~fifo_full_i : hit_ready_i;

  // a saturated counter blocks both paths
  assign desc_ready_o = ~stall_i & path_ready;

  // hits pass straight through and leave on the accepting edge
  // the hint cannot flip while a hit waits because counts only rise on a push
  assign hit_valid_o = desc_valid_i & ~miss_bound & ~stall_i;
  assign hit_o       = desc_i;

  // push and counter increment are the same signal so they never diverge
  assign push_o = desc_valid_i & miss_bound & ~stall_i & ~fifo_full_i;

  // id and rw always travel along because the counters need them for the hint
  assign cnt_up_o.id    = desc_i.id;
  assign cnt_up_o.rw    = desc_i.rw;
  assign cnt_up_o.valid = push_o;

endmodule

/* verilog/llc_miss_fifo.sv */
`timescale 1ns/10ps

module llc_miss_fifo (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               push_i,
  input  llc_pkg::llc_desc_t push_desc_i,
  output logic               full_o,
  output logic               miss_valid_o,
  output llc_pkg::llc_desc_t miss_o,
  input  logic               miss_ready_i,
  output llc_pkg::cnt_evt_t  cnt_down_o
);

  import llc_pkg::*;

  // the fill count decides which storage entries hold live descriptors
  llc_desc_t                   mem_q [MissFifoDepth];
  logic [MissFifoPtrWidth-1:0] wr_ptr_q;
  logic [MissFifoPtrWidth-1:0] rd_ptr_q;
  logic [MissFifoPtrWidth:0]   fill_q;
  logic                        do_push;
  logic                        do_pop;

  assign full_o       = (fill_q == (MissFifoPtrWidth + 1)'(MissFifoDepth));
  assign miss_valid_o = (fill_q != '0);
  assign miss_o       = mem_q[rd_ptr_q];

  // the router only pushes while not full and a pop may share the edge
  assign do_push = push_i & ~full_o;
  assign do_pop  = miss_valid_o & miss_ready_i;

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_desc_i;
    end
  end

  // the depth is a power of two so the pointers simply wrap
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        fill_q <= fill_q + 1'b1;
      end else if (do_pop && !do_push) begin
        fill_q <= fill_q - 1'b1;
      end
    end
  end

  // each transfer on the miss output releases one count of its ID
  assign cnt_down_o.id    = miss_o.id;
  assign cnt_down_o.rw    = miss_o.rw;
  assign cnt_down_o.valid = do_pop;

endmodule

/* verilog/llc_miss_counters.sv */
`timescale 1ns/10ps

module llc_miss_counters (
  input  logic              clk_i,
  input  logic              reset_i,
  // a descriptor enters the miss pipeline
  input  llc_pkg::cnt_evt_t cnt_up_i,
  // a descriptor leaves the miss pipeline
  input  llc_pkg::cnt_evt_t cnt_down_i,
  output logic              to_miss_o,
  output logic              stall_o
);

  import llc_pkg::*;

  // at-max flags, the top bit belongs to the write counter
  logic [NoCounters:0]                stall;
  logic [NoCounters-1:0]              en;
  logic [NoCounters-1:0]              down;
  miss_cnt_t [NoCounters-1:0]         q_miss;
  miss_wcnt_t                         q_write;
  logic                               en_w;
  logic                               down_w;
  logic                               up_w;
  logic                               dn_w;
  logic [UseIdBits-1:0]               up_sel;
  logic [UseIdBits-1:0]               dn_sel;

  assign up_sel = cnt_up_i.id[UseIdBits-1:0];
  assign dn_sel = cnt_down_i.id[UseIdBits-1:0];

  // an up and a down on the same counter cancel out and the count holds
  always_comb begin
    for (int unsigned i = 0; i < NoCounters; i++) begin
      en[i]   = (cnt_up_i.valid && (up_sel == UseIdBits'(i))) ^
                (cnt_down_i.valid && (dn_sel == UseIdBits'(i)));
      down[i] = cnt_down_i.valid && (dn_sel == UseIdBits'(i));
    end
  end

  // the write counter nets the write flags of both events in the same way
  assign up_w   = cnt_up_i.valid & cnt_up_i.rw;
  assign dn_w   = cnt_down_i.valid & cnt_down_i.rw;
  assign en_w   = up_w ^ dn_w;
  assign down_w = dn_w;

  // the hint uses the registered counts, so a pop on this edge is not seen yet
  assign to_miss_o = (q_miss[up_sel] != '0) || (cnt_up_i.rw && (q_write != '0));

  // any saturated counter holds the input until the pipeline drains
  assign stall_o = |stall;

  for (genvar j = 0; j < NoCounters; j++) begin : gen_id_cnt
    llc_updown_counter #(
      .Width    ( MissCntWidth )
    ) u_id_cnt (
      .clk_i    ( clk_i        ),
      .reset_i  ( reset_i      ),
      .en_i     ( en[j]        ),
      .down_i   ( down[j]      ),
      .q_o      ( q_miss[j]    ),
      .at_max_o ( stall[j]     )
    );
  end

  llc_updown_counter #(
    .Width    ( MissCntWWidth     )
  ) u_write_cnt (
    .clk_i    ( clk_i             ),
    .reset_i  ( reset_i           ),
    .en_i     ( en_w              ),
    .down_i   ( down_w            ),
    .q_o      ( q_write           ),
    .at_max_o ( stall[NoCounters] )
  );

endmodule

/* verilog/llc_updown_counter.sv */
`timescale 1ns/10ps

module llc_updown_counter #(
  parameter int unsigned Width = 2
) (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             en_i,
  input  logic             down_i,
  output logic [Width-1:0] q_o,
  output logic             at_max_o
);

  logic [Width-1:0] cnt_q;
  logic [Width-1:0] cnt_d;

  // the counter takes one step per enabled cycle in the direction given by down_i
  always_comb begin
    cnt_d = cnt_q;
    if (en_i) begin
      if (down_i) begin
        cnt_d = cnt_q - 1'b1;
      end else begin
        cnt_d = cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  assign q_o = cnt_q;
  // all ones means the next up step would wrap to zero
  assign at_max_o = &cnt_q;

endmodule

/* verilog/llc_pkg.sv */
package llc_pkg;

  // the full AXI ID carried by every descriptor
  localparam int unsigned IdWidth = 6;

  // only the low ID bits pick a miss counter, so several IDs can share one
  localparam int unsigned UseIdBits = 2;
  localparam int unsigned NoCounters = 2 ** UseIdBits;

  // a per-ID counter saturates at 3 outstanding misses
  localparam int unsigned MissCntWidth = 2;

  // the write counter saturates at 7 outstanding writes
  localparam int unsigned MissCntWWidth = 3;

  // entries of the miss pipeline and the pointer width that walks them
  localparam int unsigned MissFifoDepth = 8;
  localparam int unsigned MissFifoPtrWidth = $clog2(MissFifoDepth);

  typedef logic [IdWidth-1:0]       llc_id_t;
  typedef logic [MissCntWidth-1:0]  miss_cnt_t;
  typedef logic [MissCntWWidth-1:0] miss_wcnt_t;

  // one descriptor as it leaves the tag lookup
  typedef struct packed {
    llc_id_t    id;
    // 0 is a read and 1 is a write
    logic       rw;
    // set by the tag lookup when the line is not present
    logic       miss;
    // payload that only serves tracing
    logic [7:0] tag;
  } llc_desc_t;

  // one step for the miss counters, valid acts as the counter enable
  typedef struct packed {
    llc_id_t id;
    logic    rw;
    logic    valid;
  } cnt_evt_t;

endpackage
